// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert
TOP      := sv39_ptw_tb
FILELIST := sv39_ptw.f
BUILD    := obj_dir
LOG      := sim.log
RUN_ARGS := +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: dv/ptw_assertions.sv
// ====================
// Walker handshake and pulse properties, bound to the walk FSM
// ====================
`timescale 1ns/1ps

module ptw_assertions (
    input logic clk_i,
    input logic rst_ni,
    input logic req_valid_i,
    input logic req_ready_i,
    input logic update_i,
    input logic error_i
);

    // Number of failed properties, read by the testbench top
    int unsigned violations = 0;

    // A request that was not taken must still be there next cycle
    a_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        req_valid_i && !req_ready_i |=> req_valid_i)
    else begin
        violations++;
        $error("memory request dropped before it was accepted");
    end

    // A walk ends either with an update or with an error
    a_end_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(update_i && error_i))
    else begin
        violations++;
        $error("update and error raised in the same cycle");
    end

    // Error is a single cycle pulse
    a_err_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        error_i |=> !error_i)
    else begin
        violations++;
        $error("error output held for more than one cycle");
    end

endmodule

bind ptw_walk_ctrl ptw_assertions u_walk_assert (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_valid_i(mem_req_valid_o),
    .req_ready_i(mem_req_ready_i),
    .update_i   (update_o),
    .error_i    (ptw_error_o)
);

// File: dv/ptw_scoreboard.sv
// ====================
// Output checker for the walker with one result line per test
// ====================
`timescale 1ns/1ps

module ptw_scoreboard
    import sv39_pkg::*;
    import iommu_pkg::*;
#(
    parameter int unsigned PscidWidth = 20
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    // Test framing and expectations from the trace
    input  logic                  test_start_i,
    input  logic                  test_done_i,
    input  logic [127:0]          test_name_i,
    input  logic [1:0]            exp_kind_i,
    input  pte_t                  exp_val_i,
    input  vpn_t                  exp_vpn_i,
    input  logic [PscidWidth-1:0] exp_pscid_i,
    // Observed DUT outputs
    input  logic                  mem_req_valid_i,
    input  logic                  mem_rsp_ready_i,
    input  logic                  update_i,
    input  vpn_t                  up_vpn_i,
    input  logic [PscidWidth-1:0] up_pscid_i,
    input  logic                  up_is_1g_i,
    input  logic                  up_is_2m_i,
    input  pte_t                  up_content_i,
    input  logic                  ptw_error_i,
    input  cause_t                cause_code_i,
    input  logic                  ptw_active_i,
    output int unsigned           pass_cnt_o,
    output int unsigned           fail_cnt_o
);

    // Expected end kinds
    localparam logic [1:0] KIND_2M  = 2'd1;
    localparam logic [1:0] KIND_1G  = 2'd2;
    localparam logic [1:0] KIND_ERR = 2'd3;

    int unsigned n_end;
    int unsigned n_bad;
    logic        end_seen_q;
    logic        restart_q;
    logic        reset_chk_q;

    task automatic check_val(input string what, input logic [63:0] exp,
                             input logic [63:0] act);
        if (exp !== act) begin
            $display("ERR %s %0s expected %h actual %h", test_name_i, what, exp, act);
            n_bad++;
        end
    endtask

    // Compare the end event against the trace line
    task automatic compare_end();
        if (exp_kind_i == KIND_ERR) begin
            if (update_i) begin
                $display("%s: IOTLB update seen where a fault was expected", test_name_i);
                n_bad++;
            end else begin
                check_val("cause", exp_val_i, 64'(cause_code_i));
            end
        end else if (ptw_error_i) begin
            $display("%s: fault with cause %h where an update was expected",
                     test_name_i, cause_code_i);
            n_bad++;
        end else begin
            check_val("content", exp_val_i, up_content_i);
            check_val("vpn", 64'(exp_vpn_i), 64'(up_vpn_i));
            check_val("pscid", 64'(exp_pscid_i), 64'(up_pscid_i));
            check_val("is_1g", 64'(exp_kind_i == KIND_1G), 64'(up_is_1g_i));
            check_val("is_2m", 64'(exp_kind_i == KIND_2M), 64'(up_is_2m_i));
        end
    endtask

    // Sample mid cycle away from the driving edge
    always @(negedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            n_end       = 0;
            n_bad       = 0;
            end_seen_q  <= 1'b0;
            restart_q   <= 1'b0;
            reset_chk_q <= 1'b1;
            pass_cnt_o  <= 0;
            fail_cnt_o  <= 0;
        end else begin
            // Outputs are quiet in the first cycle out of reset
            if (reset_chk_q) begin
                reset_chk_q <= 1'b0;
                if (mem_req_valid_i || mem_rsp_ready_i || update_i || ptw_error_i ||
                    ptw_active_i) begin
                    $display("FAILED reset_idle: walker outputs not low after reset");
                    fail_cnt_o <= fail_cnt_o + 1;
                end else begin
                    $display("PASSED reset_idle");
                    pass_cnt_o <= pass_cnt_o + 1;
                end
            end
            if (test_start_i) begin
                n_end = 0;
                n_bad = 0;
                restart_q <= 1'b0;
            end
            // Walker must be idle right after its end event
            if (end_seen_q && ptw_active_i) begin
                $display("%s: walker still active after the end of the walk", test_name_i);
                n_bad++;
            end
            // A held trigger must not start another walk
            if (n_end > 0 && mem_req_valid_i && !restart_q) begin
                $display("%s: held trigger started a second walk", test_name_i);
                restart_q <= 1'b1;
                n_bad++;
            end
            if (update_i || ptw_error_i) begin
                n_end++;
                if (n_end > 1) begin
                    $display("%s: more than one end event in a single test", test_name_i);
                    n_bad++;
                end else begin
                    compare_end();
                end
            end
            end_seen_q <= update_i || ptw_error_i;
            if (test_done_i) begin
                if (n_end == 0) begin
                    $display("%s: walk never ended with an update or an error", test_name_i);
                    n_bad++;
                end
                if (n_bad == 0) begin
                    $display("PASSED %s", test_name_i);
                    pass_cnt_o <= pass_cnt_o + 1;
                end else begin
                    $display("FAILED %s with %0d problems", test_name_i, n_bad);
                    fail_cnt_o <= fail_cnt_o + 1;
                end
            end
        end
    end

endmodule

// File: dv/ptw_trace.txt
# M <pte address> <pte value> <bus error flag>
# T <name> <iova> <is_store> <pscid> <root ppn> <U4K|U2M|U1G|ERR> <leaf content or cause>
M 100008 0000000000040401 0
M 101010 0000000000040801 0
M 102018 00000000000800c7 0
M 100010 00000000100000c7 0
M 100018 0000000000040c21 0
M 103028 0000000000100043 0
M 100028 0040000000040401 0
M 100030 00000000000804c7 0
M 102020 0000000000040401 0
M 100038 0000000000000000 1
T walk_4k     0040403000 0 12345 100 U4K 00000000000800c7
T leaf_1g     0080000000 1 00abc 100 U1G 00000000100000c7
T leaf_2m_g   00c0a00000 0 00001 100 U2M 0000000000100063
T invalid_ld  0100000000 0 00002 100 ERR 000000000000000d
T invalid_st  0100000000 1 00003 100 ERR 000000000000000f
T rsvd_bits   0140000000 0 00004 100 ERR 000000000000000d
T misalign_1g 0180000000 1 00005 100 ERR 000000000000000f
T ptr_at_lvl3 0040404000 0 00006 100 ERR 000000000000000d
T store_no_d  00c0a00000 1 00007 100 ERR 000000000000000f
T bus_error   01c0000000 0 00008 100 ERR 0000000000000112

// File: dv/sv39_ptw_tb.sv
// ====================
// Testbench top, trace reader, PTE memory model and run control
// ====================
`timescale 1ns/1ps

module sv39_ptw_tb
    import sv39_pkg::*;
    import iommu_pkg::*;
();

    localparam int RST_CYCLES  = 5;
    localparam int LVL_CYCLES  = 10;
    localparam int HOLD_CYCLES = 12;
    localparam int MAX_TESTS   = 32;
    localparam int PSCID_W     = 20;

    logic clk_i;
    logic rst_n = 1'b0;

    // DUT inputs
    logic               init_ptw     = 1'b0;
    logic               is_store     = 1'b0;
    iova_t              req_iova     = '0;
    logic [PSCID_W-1:0] pscid        = '0;
    ppn_t               iosatp_ppn   = '0;
    logic               mem_req_ready = 1'b0;
    logic               mem_rsp_valid = 1'b0;
    pte_t               mem_rsp_data  = '0;
    logic               mem_rsp_err   = 1'b0;

    // DUT outputs
    logic               mem_req_valid;
    paddr_t             mem_req_addr;
    logic               mem_rsp_ready;
    logic               update;
    vpn_t               up_vpn;
    logic [PSCID_W-1:0] up_pscid;
    logic               up_is_1g;
    logic               up_is_2m;
    pte_t               up_content;
    logic               ptw_error;
    cause_t             cause_code;
    logic               ptw_active;

    // Expectations handed to the scoreboard
    logic               test_start = 1'b0;
    logic               test_done  = 1'b0;
    logic [127:0]       exp_name   = '0;
    logic [1:0]         exp_kind   = '0;
    pte_t               exp_val    = '0;
    vpn_t               exp_vpn    = '0;
    logic [PSCID_W-1:0] exp_pscid  = '0;
    int unsigned        pass_cnt;
    int unsigned        fail_cnt;

    // Trace contents
    logic [127:0]       t_name  [MAX_TESTS];
    iova_t              t_iova  [MAX_TESTS];
    logic               t_store [MAX_TESTS];
    logic [PSCID_W-1:0] t_pscid [MAX_TESTS];
    ppn_t               t_ppn   [MAX_TESTS];
    logic [1:0]         t_kind  [MAX_TESTS];
    pte_t               t_val   [MAX_TESTS];
    pte_t               mem_data [paddr_t];
    logic               mem_err  [paddr_t];
    int                 n_tests  = 0;
    logic               trace_ok = 1'b1;

    // Memory model state
    int     seed = 32'ha1237c55;
    logic   pending = 1'b0;
    paddr_t pend_addr = '0;
    int     delay = 0;

    int cycle_cnt   = 0;
    int cycle_limit = 100000;

    tb_clk_gen #(.PeriodNs(4.0)) u_clk_gen (.clk_o(clk_i));

    sv39_ptw #(
        .PscidWidth(PSCID_W)
    ) dut_i (
        .clk_i          (clk_i),
        .rst_ni         (rst_n),
        .init_ptw_i     (init_ptw),
        .is_store_i     (is_store),
        .req_iova_i     (req_iova),
        .pscid_i        (pscid),
        .iosatp_ppn_i   (iosatp_ppn),
        .mem_req_valid_o(mem_req_valid),
        .mem_req_ready_i(mem_req_ready),
        .mem_req_addr_o (mem_req_addr),
        .mem_rsp_valid_i(mem_rsp_valid),
        .mem_rsp_ready_o(mem_rsp_ready),
        .mem_rsp_data_i (mem_rsp_data),
        .mem_rsp_err_i  (mem_rsp_err),
        .update_o       (update),
        .up_vpn_o       (up_vpn),
        .up_pscid_o     (up_pscid),
        .up_is_1g_o     (up_is_1g),
        .up_is_2m_o     (up_is_2m),
        .up_content_o   (up_content),
        .ptw_error_o    (ptw_error),
        .cause_code_o   (cause_code),
        .ptw_active_o   (ptw_active)
    );

    ptw_scoreboard #(
        .PscidWidth(PSCID_W)
    ) u_scoreboard (
        .clk_i          (clk_i),
        .rst_ni         (rst_n),
        .test_start_i   (test_start),
        .test_done_i    (test_done),
        .test_name_i    (exp_name),
        .exp_kind_i     (exp_kind),
        .exp_val_i      (exp_val),
        .exp_vpn_i      (exp_vpn),
        .exp_pscid_i    (exp_pscid),
        .mem_req_valid_i(mem_req_valid),
        .mem_rsp_ready_i(mem_rsp_ready),
        .update_i       (update),
        .up_vpn_i       (up_vpn),
        .up_pscid_i     (up_pscid),
        .up_is_1g_i     (up_is_1g),
        .up_is_2m_i     (up_is_2m),
        .up_content_i   (up_content),
        .ptw_error_i    (ptw_error),
        .cause_code_i   (cause_code),
        .ptw_active_i   (ptw_active),
        .pass_cnt_o     (pass_cnt),
        .fail_cnt_o     (fail_cnt)
    );

    // Memory lines fill the model, test lines fill the vector arrays
    task automatic read_trace();
        int           fd;
        int           code;
        string        line;
        paddr_t       addr;
        pte_t         data;
        logic         err;
        logic [127:0] name;
        logic [23:0]  kind;
        fd = $fopen("dv/ptw_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file dv/ptw_trace.txt");
            trace_ok = 1'b0;
            return;
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0 || line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            if (line.getc(0) == "M") begin
                code = $sscanf(line, "M %h %h %h", addr, data, err);
                mem_data[addr] = data;
                mem_err[addr]  = err;
            end else if (line.getc(0) == "T" && n_tests < MAX_TESTS) begin
                code = $sscanf(line, "T %s %h %h %h %h %s %h", name, t_iova[n_tests],
                               t_store[n_tests], t_pscid[n_tests], t_ppn[n_tests],
                               kind, t_val[n_tests]);
                t_name[n_tests] = name;
                case (kind)
                    "U4K":   t_kind[n_tests] = 2'd0;
                    "U2M":   t_kind[n_tests] = 2'd1;
                    "U1G":   t_kind[n_tests] = 2'd2;
                    "ERR":   t_kind[n_tests] = 2'd3;
                    default: begin
                        $display("Unknown result kind in trace line: %s", line);
                        trace_ok = 1'b0;
                    end
                endcase
                n_tests++;
            end
        end
        $fclose(fd);
    endtask

    // One walk, then the trigger stays high to show no second walk starts
    task automatic run_test(input int idx);
        int waited;
        @(posedge clk_i);
        init_ptw   <= 1'b1;
        is_store   <= t_store[idx];
        req_iova   <= t_iova[idx];
        pscid      <= t_pscid[idx];
        iosatp_ppn <= t_ppn[idx];
        exp_name   <= t_name[idx];
        exp_kind   <= t_kind[idx];
        exp_val    <= t_val[idx];
        exp_vpn    <= t_iova[idx][38:12];
        exp_pscid  <= t_pscid[idx];
        test_start <= 1'b1;
        @(posedge clk_i);
        test_start <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk_i);
            waited++;
        end while (!(update || ptw_error) && waited < 3 * LVL_CYCLES);
        repeat (HOLD_CYCLES) @(negedge clk_i);
        @(posedge clk_i);
        init_ptw  <= 1'b0;
        test_done <= 1'b1;
        @(posedge clk_i);
        test_done <= 1'b0;
    endtask

    // PTE memory with random accept stalls and 1 to 4 cycle read latency
    always @(posedge clk_i) begin
        if (!rst_n) begin
            mem_req_ready <= 1'b0;
            mem_rsp_valid <= 1'b0;
            pending       <= 1'b0;
        end else begin
            mem_req_ready <= 1'($random(seed));
            if (mem_req_valid && mem_req_ready) begin
                pending   <= 1'b1;
                pend_addr <= mem_req_addr;
                delay     <= $random(seed) & 3;
            end else if (pending) begin
                if (delay == 0) begin
                    pending       <= 1'b0;
                    mem_rsp_valid <= 1'b1;
                    // Unmapped addresses read as an invalid PTE
                    mem_rsp_data  <= mem_data.exists(pend_addr) ? mem_data[pend_addr] : '0;
                    mem_rsp_err   <= mem_err.exists(pend_addr) ? mem_err[pend_addr] : 1'b0;
                end else begin
                    delay <= delay - 1;
                end
            end
            if (mem_rsp_valid && mem_rsp_ready) begin
                mem_rsp_valid <= 1'b0;
            end
        end
    end

    // Hard stop for a walker that never finishes
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout after %0d cycles, the walks did not complete", cycle_cnt);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        read_trace();
        cycle_limit = n_tests * (3 * LVL_CYCLES + HOLD_CYCLES + 4) + RST_CYCLES + 10;
        repeat (RST_CYCLES) @(posedge clk_i);
        rst_n <= 1'b1;
        @(posedge clk_i);
        for (int i = 0; i < n_tests; i++) begin
            run_test(i);
        end
        repeat (4) @(posedge clk_i);
        $display("Tests run %0d, passed %0d, failed %0d, assertion failures %0d",
                 n_tests + 1, pass_cnt, fail_cnt,
                 dut_i.u_walk_ctrl.u_walk_assert.violations);
        if (trace_ok && n_tests > 0 && fail_cnt == 0 && pass_cnt == n_tests + 1 &&
            dut_i.u_walk_ctrl.u_walk_assert.violations == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: dv/tb_clk_gen.sv
// ====================
// Testbench clock source
// ====================
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PeriodNs = 4.0
) (
    output logic clk_o
);

    // Free running, starts low
    initial begin
        clk_o = 1'b0;
        forever #(PeriodNs / 2.0) clk_o = ~clk_o;
    end

endmodule

// File: rtl/iommu_pkg.sv
// ====================
// IOMMU cause codes and walker states
// ====================
package iommu_pkg;

    // Fault cause code as reported to the IOMMU
    typedef logic [11:0] cause_t;

    // Page faults follow the privileged spec exception codes
    localparam cause_t LOAD_PAGE_FAULT    = cause_t'(13);
    localparam cause_t STORE_PAGE_FAULT   = cause_t'(15);

    // Bus error while fetching a PTE
    localparam cause_t PT_DATA_CORRUPTION = cause_t'(274);

    // Page table walker FSM
    typedef enum logic [1:0] {
        IDLE,
        MEM_ACCESS,
        PROC_PTE,
        ERROR
    } ptw_state_e;

endpackage

// File: rtl/iotlb_update_gen.sv
// ====================
// IOTLB update fields and global tracking
// ====================
`timescale 1ns/1ps

module iotlb_update_gen
    import sv39_pkg::*;
#(
    parameter int unsigned PscidWidth = 20
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  capture_i,
    input  logic                  update_i,
    input  logic                  pte_valid_i,
    input  logic                  global_i,
    input  page_lvl_e             lvl_i,
    input  iova_t                 req_iova_i,
    input  logic [PscidWidth-1:0] pscid_i,
    input  pte_t                  pte_i,
    output vpn_t                  up_vpn_o,
    output logic [PscidWidth-1:0] up_pscid_o,
    output logic                  up_is_1g_o,
    output logic                  up_is_2m_o,
    output pte_t                  up_content_o
);

    vpn_t                  vpn_q;
    logic [PscidWidth-1:0] pscid_q;
    logic                  global_q;

    // Tags are taken at walk start
    always_ff @(posedge clk_i) begin
        if (capture_i) begin
            vpn_q   <= req_iova_i[38:12];
            pscid_q <= pscid_i;
        end
    end

    // Sticky G from any PTE seen on this walk
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            global_q <= 1'b0;
        end else if (capture_i) begin
            global_q <= 1'b0;
        end else if (pte_valid_i && global_i) begin
            global_q <= 1'b1;
        end
    end

    // Fields are zero outside the update pulse
    always_comb begin
        up_vpn_o     = update_i ? vpn_q : '0;
        up_pscid_o   = update_i ? pscid_q : '0;
        up_is_1g_o   = update_i && (lvl_i == LVL1);
        up_is_2m_o   = update_i && (lvl_i == LVL2);
        up_content_o = update_i ? pte_i : '0;
        // Inherit G from upper levels
        up_content_o[PTE_G] = update_i && (pte_i[PTE_G] || global_q);
    end

endmodule

// File: rtl/pte_checker.sv
// ====================
// Sv39 PTE legality checks
// ====================
`timescale 1ns/1ps

module pte_checker
    import sv39_pkg::*;
(
    input  pte_t      pte_i,
    input  page_lvl_e lvl_i,
    input  logic      is_store_i,
    output logic      is_leaf_o,
    output logic      fault_o,
    output logic      global_o
);

    ppn_t ppn;
    logic invalid;
    logic rsvd_set;
    logic misaligned;
    logic leaf_perm_bad;
    logic ptr_bits_bad;
    logic ptr_at_last;

    assign ppn = pte_i[PTE_RSVD_LSB-1:PTE_PPN_LSB];

    // Any of R or X marks a leaf
    assign is_leaf_o = pte_i[PTE_R] || pte_i[PTE_X];
    assign global_o  = pte_i[PTE_G];

    // Not valid, or write-only encoding
    assign invalid  = !pte_i[PTE_V] || (!pte_i[PTE_R] && pte_i[PTE_W]);

    // Bits [63:54] must be zero
    assign rsvd_set = |pte_i[$bits(pte_t)-1:PTE_RSVD_LSB];

    // Superpage PPN must be aligned to the page size
    assign misaligned = ((lvl_i == LVL1) && (|ppn[17:0])) ||
                        ((lvl_i == LVL2) && (|ppn[8:0]));

    // Leaf needs A and R, stores need D too
    assign leaf_perm_bad = !pte_i[PTE_A] || !pte_i[PTE_R] ||
                           (is_store_i && !pte_i[PTE_D]);

    // D, A, U are reserved on pointer PTEs
    assign ptr_bits_bad = pte_i[PTE_A] || pte_i[PTE_D] || pte_i[PTE_U];

    // No table below level 3
    assign ptr_at_last  = (lvl_i == LVL3);

    always_comb begin
        fault_o = invalid || rsvd_set;
        if (is_leaf_o) begin
            fault_o = fault_o || misaligned || leaf_perm_bad;
        end else begin
            fault_o = fault_o || ptr_bits_bad || ptr_at_last;
        end
    end

endmodule

// File: rtl/ptw_addr_gen.sv
// ====================
// PTE pointer register and next-level address
// ====================
`timescale 1ns/1ps

module ptw_addr_gen
    import sv39_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      load_root_i,
    input  logic      load_next_i,
    input  page_lvl_e lvl_i,
    input  ppn_t      iosatp_ppn_i,
    input  iova_t     req_iova_i,
    input  pte_t      pte_i,
    output paddr_t    pptr_o
);

    iova_t      iova_q;
    paddr_t     pptr_q;
    paddr_t     root_pptr;
    paddr_t     next_pptr;
    ppn_t       pte_ppn;
    logic [8:0] vpn_seg;

    assign pte_ppn = pte_i[PTE_RSVD_LSB-1:PTE_PPN_LSB];

    // Root table is indexed by VPN[2] of the incoming request
    assign root_pptr = {iosatp_ppn_i, req_iova_i[38:30], 3'b000};

    // Index for the table one below the current level
    always_comb begin
        case (lvl_i)
            LVL1:    vpn_seg = iova_q[29:21];
            default: vpn_seg = iova_q[20:12];
        endcase
    end

    // 8 byte PTEs, so the index is shifted by three
    assign next_pptr = {pte_ppn, vpn_seg, 3'b000};

    // IOVA is kept for the lower-level indices
    always_ff @(posedge clk_i) begin
        if (load_root_i) begin
            iova_q <= req_iova_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pptr_q <= '0;
        end else if (load_root_i) begin
            pptr_q <= root_pptr;
        end else if (load_next_i) begin
            pptr_q <= next_pptr;
        end
    end

    assign pptr_o = pptr_q;

endmodule

// File: rtl/ptw_walk_ctrl.sv
// ====================
// Walk FSM, level tracking and fault sequencing
// ====================
`timescale 1ns/1ps

module ptw_walk_ctrl
    import sv39_pkg::*;
    import iommu_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      init_ptw_i,
    input  logic      is_store_i,
    input  logic      mem_req_ready_i,
    input  logic      mem_rsp_valid_i,
    input  logic      mem_rsp_err_i,
    input  logic      is_leaf_i,
    input  logic      pte_fault_i,
    output logic      mem_req_valid_o,
    output logic      mem_rsp_ready_o,
    output page_lvl_e lvl_o,
    output logic      load_root_o,
    output logic      load_next_o,
    output logic      capture_o,
    output logic      update_o,
    output logic      ptw_error_o,
    output cause_t    cause_code_o,
    output logic      ptw_active_o
);

    ptw_state_e state_q, state_n;
    page_lvl_e  lvl_q, lvl_n;
    cause_t     cause_q, cause_n;
    logic       trig_q;

    logic start;
    logic rsp_fire;
    logic pte_ok;

    // Only a rising edge on the trigger starts a walk
    assign start    = (state_q == IDLE) && init_ptw_i && !trig_q;

    // Response is consumed as soon as it shows up in PROC_PTE
    assign rsp_fire = (state_q == PROC_PTE) && mem_rsp_valid_i;

    // Good data and the checker found nothing wrong
    assign pte_ok   = rsp_fire && !mem_rsp_err_i && !pte_fault_i;

    // Memory port handshake
    assign mem_req_valid_o = (state_q == MEM_ACCESS);
    assign mem_rsp_ready_o = rsp_fire;

    // Start of walk strobes
    assign load_root_o = start;
    assign capture_o   = start;

    // Leaf ends the walk, a pointer PTE descends
    assign update_o    = pte_ok && is_leaf_i;
    assign load_next_o = pte_ok && !is_leaf_i;

    // Error is reported from the one-cycle ERROR state
    assign ptw_error_o  = (state_q == ERROR);
    assign cause_code_o = (state_q == ERROR) ? cause_q : '0;

    assign ptw_active_o = (state_q != IDLE);
    assign lvl_o        = lvl_q;

    always_comb begin
        state_n = state_q;
        lvl_n   = lvl_q;
        cause_n = cause_q;

        case (state_q)
            IDLE: begin
                if (start) begin
                    state_n = MEM_ACCESS;
                    lvl_n   = LVL1;
                end
            end
            // Hold the request until the memory takes it
            MEM_ACCESS: begin
                if (mem_req_ready_i) begin
                    state_n = PROC_PTE;
                end
            end
            PROC_PTE: begin
                if (rsp_fire) begin
                    if (mem_rsp_err_i) begin
                        // Bus error wins over any PTE check
                        state_n = ERROR;
                        cause_n = PT_DATA_CORRUPTION;
                    end else if (pte_fault_i) begin
                        state_n = ERROR;
                        cause_n = is_store_i ? STORE_PAGE_FAULT : LOAD_PAGE_FAULT;
                    end else if (is_leaf_i) begin
                        state_n = IDLE;
                    end else begin
                        state_n = MEM_ACCESS;
                        // LVL3 pointer is a checker fault, never reaches here
                        lvl_n   = (lvl_q == LVL1) ? LVL2 : LVL3;
                    end
                end
            end
            ERROR: begin
                state_n = IDLE;
            end
            default: begin
                state_n = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            lvl_q   <= LVL1;
            cause_q <= '0;
            trig_q  <= 1'b0;
        end else begin
            state_q <= state_n;
            lvl_q   <= lvl_n;
            cause_q <= cause_n;
            trig_q  <= init_ptw_i;
        end
    end

endmodule

// File: rtl/sv39_pkg.sv
// ====================
// Sv39 address and PTE format definitions
// ====================
package sv39_pkg;

    // Virtual I/O address, 3 x 9 bit VPN plus 12 bit offset
    typedef logic [38:0] iova_t;

    // Physical address of a PTE in memory
    typedef logic [55:0] paddr_t;

    // Physical page number held in a PTE or in iosatp
    typedef logic [43:0] ppn_t;

    // Full virtual page number {VPN[2], VPN[1], VPN[0]}
    typedef logic [26:0] vpn_t;

    // Raw page table entry as read from memory
    typedef logic [63:0] pte_t;

    // PTE flag bit positions
    localparam int unsigned PTE_V = 0;
    localparam int unsigned PTE_R = 1;
    localparam int unsigned PTE_W = 2;
    localparam int unsigned PTE_X = 3;
    localparam int unsigned PTE_U = 4;
    localparam int unsigned PTE_G = 5;
    localparam int unsigned PTE_A = 6;
    localparam int unsigned PTE_D = 7;

    // PPN occupies [53:10], reserved field [63:54]
    localparam int unsigned PTE_PPN_LSB  = 10;
    localparam int unsigned PTE_RSVD_LSB = 54;

    // Walk level, LVL1 is the root table
    typedef enum logic [1:0] {
        LVL1,
        LVL2,
        LVL3
    } page_lvl_e;

endpackage

// File: rtl/sv39_ptw.sv
// ====================
// Sv39 IOMMU page table walker top level
// ====================
`timescale 1ns/1ps

module sv39_ptw
    import sv39_pkg::*;
    import iommu_pkg::*;
#(
    parameter int unsigned PscidWidth = 20
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    // Walk request
    input  logic                  init_ptw_i,
    input  logic                  is_store_i,
    input  iova_t                 req_iova_i,
    input  logic [PscidWidth-1:0] pscid_i,
    input  ppn_t                  iosatp_ppn_i,
    // Memory read port
    output logic                  mem_req_valid_o,
    input  logic                  mem_req_ready_i,
    output paddr_t                mem_req_addr_o,
    input  logic                  mem_rsp_valid_i,
    output logic                  mem_rsp_ready_o,
    input  pte_t                  mem_rsp_data_i,
    input  logic                  mem_rsp_err_i,
    // IOTLB update
    output logic                  update_o,
    output vpn_t                  up_vpn_o,
    output logic [PscidWidth-1:0] up_pscid_o,
    output logic                  up_is_1g_o,
    output logic                  up_is_2m_o,
    output pte_t                  up_content_o,
    // Fault report and status
    output logic                  ptw_error_o,
    output cause_t                cause_code_o,
    output logic                  ptw_active_o
);

    page_lvl_e lvl;
    logic      load_root;
    logic      load_next;
    logic      capture;
    logic      is_leaf;
    logic      pte_fault;
    logic      pte_global;

    ptw_walk_ctrl u_walk_ctrl (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .init_ptw_i     (init_ptw_i),
        .is_store_i     (is_store_i),
        .mem_req_ready_i(mem_req_ready_i),
        .mem_rsp_valid_i(mem_rsp_valid_i),
        .mem_rsp_err_i  (mem_rsp_err_i),
        .is_leaf_i      (is_leaf),
        .pte_fault_i    (pte_fault),
        .mem_req_valid_o(mem_req_valid_o),
        .mem_rsp_ready_o(mem_rsp_ready_o),
        .lvl_o          (lvl),
        .load_root_o    (load_root),
        .load_next_o    (load_next),
        .capture_o      (capture),
        .update_o       (update_o),
        .ptw_error_o    (ptw_error_o),
        .cause_code_o   (cause_code_o),
        .ptw_active_o   (ptw_active_o)
    );

    // Checks run on the raw response word
    pte_checker u_pte_checker (
        .pte_i     (mem_rsp_data_i),
        .lvl_i     (lvl),
        .is_store_i(is_store_i),
        .is_leaf_o (is_leaf),
        .fault_o   (pte_fault),
        .global_o  (pte_global)
    );

    ptw_addr_gen u_addr_gen (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .load_root_i (load_root),
        .load_next_i (load_next),
        .lvl_i       (lvl),
        .iosatp_ppn_i(iosatp_ppn_i),
        .req_iova_i  (req_iova_i),
        .pte_i       (mem_rsp_data_i),
        .pptr_o      (mem_req_addr_o)
    );

    // Response ready marks an accepted PTE
    iotlb_update_gen #(
        .PscidWidth(PscidWidth)
    ) u_update_gen (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .capture_i   (capture),
        .update_i    (update_o),
        .pte_valid_i (mem_rsp_ready_o),
        .global_i    (pte_global),
        .lvl_i       (lvl),
        .req_iova_i  (req_iova_i),
        .pscid_i     (pscid_i),
        .pte_i       (mem_rsp_data_i),
        .up_vpn_o    (up_vpn_o),
        .up_pscid_o  (up_pscid_o),
        .up_is_1g_o  (up_is_1g_o),
        .up_is_2m_o  (up_is_2m_o),
        .up_content_o(up_content_o)
    );

endmodule

// File: sv39_ptw.f
rtl/sv39_pkg.sv
rtl/iommu_pkg.sv
rtl/ptw_walk_ctrl.sv
rtl/pte_checker.sv
rtl/ptw_addr_gen.sv
rtl/iotlb_update_gen.sv
rtl/sv39_ptw.sv
dv/tb_clk_gen.sv
dv/ptw_assertions.sv
dv/ptw_scoreboard.sv
dv/sv39_ptw_tb.sv
